// ==== muldiv_settings.svh ====
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand and result width
`define MULDIV_DATA_W 64

// command word width, shared by both decode views
`define MULDIV_CMD_W 10

// reorder buffer entries, tag width is derived in the package
`define MULDIV_ROB_SIZE 8

`endif

// ==== muldiv_pkg.sv ====
`default_nettype none

`include "muldiv_settings.svh"

package muldiv_pkg;

  localparam int TAG_W = $clog2(`MULDIV_ROB_SIZE + 1);

  typedef logic [TAG_W-1:0] rob_tag_t;

  // one bit per flag, zero in the msb
  typedef struct packed {
    logic zero;
    logic negative;
    logic overflow;
    logic div_by_zero;
  } exec_flags_t;

  // multiply view of the command word
  typedef struct packed {
    logic [3:0] op_class;
    logic       a_signed;
    logic       b_signed;
    logic       high_half;
    logic [2:0] rsvd;
  } mult_cmd_t;

  // divide view of the command word
  typedef struct packed {
    logic [3:0] op_class;
    logic       is_signed;
    logic       want_remainder;
    logic [3:0] rsvd;
  } div_cmd_t;

  // same 10 bits, decoded by whichever stage owns the op
  typedef union packed {
    mult_cmd_t mul;
    div_cmd_t  div;
  } cmd_u;

  typedef enum logic {
    UNIT_MUL = 1'b0,
    UNIT_DIV = 1'b1
  } unit_id_e;

endpackage

`default_nettype wire

// ==== exec_result_if.sv ====
`default_nettype none

`include "muldiv_settings.svh"

interface exec_result_if;
  import muldiv_pkg::*;

  logic [`MULDIV_DATA_W-1:0] result;
  cmd_u                      cmd;
  rob_tag_t                  tag;
  exec_flags_t               flags;
  logic                      valid;
  // transfer completes on the edge where valid and go are both high
  logic                      go;

  modport unit (
    output result, cmd, tag, flags, valid,
    input  go
  );

  modport arbiter (
    input  result, cmd, tag, flags, valid,
    output go
  );

endinterface

`default_nettype wire

// ==== shift_add_multiplier.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module shift_add_multiplier (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  logic [`MULDIV_DATA_W-1:0]   a_i,
  input  logic [`MULDIV_DATA_W-1:0]   b_i,
  output logic [2*`MULDIV_DATA_W-1:0] product_o,
  output logic                        done_o
);
  localparam int W = `MULDIV_DATA_W;
  localparam int CNT_W = $clog2(W) + 1;

  logic [2*W-1:0]   acc_r;
  logic [2*W-1:0]   mcand_r;
  logic [W-1:0]     mplier_r;
  logic [CNT_W-1:0] cnt_r;
  logic             done_r;

  // iteration counter, done pulses on the edge of the last add
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_r  <= '0;
      done_r <= 1'b0;
    end else if (start_i) begin
      cnt_r  <= CNT_W'(W);
      done_r <= 1'b0;
    end else begin
      done_r <= (cnt_r == CNT_W'(1));
      if (cnt_r != '0) begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

  // one partial product per cycle, lsb of the multiplier first
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      acc_r    <= '0;
      mcand_r  <= {{W{1'b0}}, a_i};
      mplier_r <= b_i;
    end else if (cnt_r != '0) begin
      if (mplier_r[0]) begin
        acc_r <= acc_r + mcand_r;
      end
      mcand_r  <= mcand_r << 1;
      mplier_r <= mplier_r >> 1;
    end
  end

  assign product_o = acc_r;
  assign done_o    = done_r;

endmodule

`default_nettype wire

// ==== mult_issue_stage.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module mult_issue_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`MULDIV_DATA_W-1:0] val1_i,
  input  logic [`MULDIV_DATA_W-1:0] val2_i,
  input  muldiv_pkg::cmd_u          cmd_i,
  input  muldiv_pkg::rob_tag_t      tag_i,
  input  logic                      ready_i,
  output logic                      stall_o,
  exec_result_if.unit               res
);
  import muldiv_pkg::*;

  localparam int W = `MULDIV_DATA_W;

  typedef enum logic [1:0] {ST_WAIT, ST_BUSY, ST_DONE} state_e;

  state_e         state_r;
  state_e         state_n;
  logic           accept_en;
  logic           accept;
  logic           a_neg;
  logic           b_neg;
  logic [W-1:0]   a_mag;
  logic [W-1:0]   b_mag;
  logic [2*W-1:0] product;
  logic           mul_done;
  cmd_u           cmd_r;
  rob_tag_t       tag_r;
  logic           neg_r;
  logic [2*W-1:0] signed_prod;
  logic [W-1:0]   sel_val;
  logic [W-1:0]   unused_half;
  logic           prod_signed;
  exec_flags_t    flags_n;
  logic [W-1:0]   res_val_r;
  exec_flags_t    flags_r;

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      ST_WAIT: begin
        if (ready_i) begin
          state_n = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (mul_done) begin
          state_n = ST_DONE;
        end
      end
      ST_DONE: begin
        if (res.go) begin
          state_n = ST_WAIT;
        end
      end
      default: state_n = ST_WAIT;
    endcase
  end

  // only an idle stage takes new work
  assign accept_en = (state_r == ST_WAIT);
  assign accept    = accept_en & ready_i;
  assign stall_o   = ~accept_en;

  // operands go in as magnitudes, sign is fixed up after done
  assign a_neg = cmd_i.mul.a_signed & val1_i[W-1];
  assign b_neg = cmd_i.mul.b_signed & val2_i[W-1];
  assign a_mag = a_neg ? -val1_i : val1_i;
  assign b_mag = b_neg ? -val2_i : val2_i;

  shift_add_multiplier u_mult (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .start_i   (accept),
    .a_i       (a_mag),
    .b_i       (b_mag),
    .product_o (product),
    .done_o    (mul_done)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= ST_WAIT;
      cmd_r   <= '0;
      tag_r   <= '0;
      neg_r   <= 1'b0;
    end else begin
      state_r <= state_n;
      if (accept) begin
        cmd_r <= cmd_i;
        tag_r <= tag_i;
        neg_r <= a_neg ^ b_neg;
      end
    end
  end

  assign signed_prod = neg_r ? -product : product;
  assign prod_signed = cmd_r.mul.a_signed | cmd_r.mul.b_signed;
  assign sel_val     = cmd_r.mul.high_half ? signed_prod[2*W-1:W] : signed_prod[W-1:0];
  assign unused_half = cmd_r.mul.high_half ? signed_prod[W-1:0] : signed_prod[2*W-1:W];

  // overflow when the other half is not just an extension of the chosen one
  always_comb begin
    flags_n.zero        = (sel_val == '0);
    flags_n.negative    = sel_val[W-1];
    flags_n.overflow    = (unused_half != {W{prod_signed & sel_val[W-1]}});
    flags_n.div_by_zero = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ST_BUSY && mul_done) begin
      res_val_r <= sel_val;
      flags_r   <= flags_n;
    end
  end

  assign res.result = res_val_r;
  assign res.cmd    = cmd_r;
  assign res.tag    = tag_r;
  assign res.flags  = flags_r;
  assign res.valid  = (state_r == ST_DONE);

endmodule

`default_nettype wire

// ==== div_issue_stage.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module div_issue_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`MULDIV_DATA_W-1:0] val1_i,
  input  logic [`MULDIV_DATA_W-1:0] val2_i,
  input  muldiv_pkg::cmd_u          cmd_i,
  input  muldiv_pkg::rob_tag_t      tag_i,
  input  logic                      ready_i,
  output logic                      stall_o,
  exec_result_if.unit               res
);
  import muldiv_pkg::*;

  localparam int W = `MULDIV_DATA_W;
  localparam int CNT_W = $clog2(W) + 1;
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  typedef enum logic [1:0] {ST_WAIT, ST_BUSY, ST_DONE} state_e;

  state_e           state_r;
  state_e           state_n;
  logic             accept_en;
  logic             accept;
  logic             a_neg;
  logic             b_neg;
  logic [W-1:0]     a_mag;
  logic [W-1:0]     b_mag;
  cmd_u             cmd_r;
  rob_tag_t         tag_r;
  logic [W-1:0]     dividend_r;
  logic             q_neg_r;
  logic             r_neg_r;
  logic             dz_r;
  logic             ovf_r;
  logic [W-1:0]     rem_r;
  logic [W-1:0]     quo_r;
  logic [W-1:0]     dsr_r;
  logic [CNT_W-1:0] cnt_r;
  logic             div_done;
  logic [W:0]       shifted;
  logic [W:0]       trial;
  logic             fits;
  logic [W-1:0]     q_sel;
  logic [W-1:0]     r_sel;
  logic [W-1:0]     sel_val;
  exec_flags_t      flags_n;
  logic [W-1:0]     res_val_r;
  exec_flags_t      flags_r;

  always_comb begin
    state_n = state_r;
    unique case (state_r)
      ST_WAIT: begin
        if (ready_i) begin
          state_n = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (div_done) begin
          state_n = ST_DONE;
        end
      end
      ST_DONE: begin
        if (res.go) begin
          state_n = ST_WAIT;
        end
      end
      default: state_n = ST_WAIT;
    endcase
  end

  assign accept_en = (state_r == ST_WAIT);
  assign accept    = accept_en & ready_i;
  assign stall_o   = ~accept_en;

  assign a_neg = cmd_i.div.is_signed & val1_i[W-1];
  assign b_neg = cmd_i.div.is_signed & val2_i[W-1];
  assign a_mag = a_neg ? -val1_i : val1_i;
  assign b_mag = b_neg ? -val2_i : val2_i;

  // control state, including the special cases decided at issue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r  <= ST_WAIT;
      cmd_r    <= '0;
      tag_r    <= '0;
      q_neg_r  <= 1'b0;
      r_neg_r  <= 1'b0;
      dz_r     <= 1'b0;
      ovf_r    <= 1'b0;
      cnt_r    <= '0;
      div_done <= 1'b0;
    end else begin
      state_r <= state_n;
      if (accept) begin
        cmd_r    <= cmd_i;
        tag_r    <= tag_i;
        q_neg_r  <= a_neg ^ b_neg;
        r_neg_r  <= a_neg;
        dz_r     <= (val2_i == '0);
        ovf_r    <= cmd_i.div.is_signed && (val1_i == MOST_NEG) && (val2_i == '1);
        cnt_r    <= CNT_W'(W);
        div_done <= 1'b0;
      end else begin
        div_done <= (cnt_r == CNT_W'(1));
        if (cnt_r != '0) begin
          cnt_r <= cnt_r - 1'b1;
        end
      end
    end
  end

  // restoring step, dividend bits shift out of quo_r as quotient bits shift in
  assign shifted = {rem_r, quo_r[W-1]};
  assign trial   = shifted - {1'b0, dsr_r};
  assign fits    = (shifted >= {1'b0, dsr_r});

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dividend_r <= val1_i;
      rem_r      <= '0;
      quo_r      <= a_mag;
      dsr_r      <= b_mag;
    end else if (cnt_r != '0) begin
      rem_r <= fits ? trial[W-1:0] : shifted[W-1:0];
      quo_r <= {quo_r[W-2:0], fits};
    end
  end

  // sign correction and the two special cases
  always_comb begin
    if (dz_r) begin
      q_sel = '1;
      r_sel = dividend_r;
    end else if (ovf_r) begin
      q_sel = MOST_NEG;
      r_sel = '0;
    end else begin
      q_sel = q_neg_r ? -quo_r : quo_r;
      r_sel = r_neg_r ? -rem_r : rem_r;
    end
  end

  assign sel_val = cmd_r.div.want_remainder ? r_sel : q_sel;

  always_comb begin
    flags_n.zero        = (sel_val == '0);
    flags_n.negative    = sel_val[W-1];
    flags_n.overflow    = ovf_r;
    flags_n.div_by_zero = dz_r;
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ST_BUSY && div_done) begin
      res_val_r <= sel_val;
      flags_r   <= flags_n;
    end
  end

  assign res.result = res_val_r;
  assign res.cmd    = cmd_r;
  assign res.tag    = tag_r;
  assign res.flags  = flags_r;
  assign res.valid  = (state_r == ST_DONE);

endmodule

`default_nettype wire

// ==== result_arbiter.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module result_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  exec_result_if.arbiter            mul_res,
  exec_result_if.arbiter            div_res,
  output logic [`MULDIV_DATA_W-1:0] result_val_o,
  output logic [`MULDIV_CMD_W-1:0]  result_cmd_o,
  output muldiv_pkg::rob_tag_t      result_tag_o,
  output muldiv_pkg::exec_flags_t   result_flags_o,
  output logic                      result_valid_o,
  input  logic                      result_ready_i
);
  import muldiv_pkg::*;

  unit_id_e rr_ptr_r;
  logic     lock_r;
  unit_id_e lock_unit_r;
  unit_id_e grant;
  logic     xfer;

  // a stalled grant is locked so the bus fields hold until taken
  always_comb begin
    if (lock_r) begin
      grant = lock_unit_r;
    end else if (mul_res.valid && div_res.valid) begin
      grant = rr_ptr_r;
    end else if (div_res.valid) begin
      grant = UNIT_DIV;
    end else begin
      grant = UNIT_MUL;
    end
  end

  assign result_valid_o = mul_res.valid | div_res.valid;
  assign xfer           = result_valid_o & result_ready_i;
  assign mul_res.go     = xfer & (grant == UNIT_MUL);
  assign div_res.go     = xfer & (grant == UNIT_DIV);

  assign result_val_o   = (grant == UNIT_DIV) ? div_res.result : mul_res.result;
  assign result_cmd_o   = (grant == UNIT_DIV) ? div_res.cmd : mul_res.cmd;
  assign result_tag_o   = (grant == UNIT_DIV) ? div_res.tag : mul_res.tag;
  assign result_flags_o = (grant == UNIT_DIV) ? div_res.flags : mul_res.flags;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_r    <= UNIT_MUL;
      lock_r      <= 1'b0;
      lock_unit_r <= UNIT_MUL;
    end else begin
      lock_r      <= result_valid_o & ~result_ready_i;
      lock_unit_r <= grant;
      // next contested cycle favours the unit that was not served
      if (xfer) begin
        rr_ptr_r <= (grant == UNIT_MUL) ? UNIT_DIV : UNIT_MUL;
      end
    end
  end

endmodule

`default_nettype wire

// ==== muldiv_exec_unit.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_exec_unit (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // multiply reservation station
  input  logic [`MULDIV_DATA_W-1:0] mul_val1_i,
  input  logic [`MULDIV_DATA_W-1:0] mul_val2_i,
  input  logic [`MULDIV_CMD_W-1:0]  mul_cmd_i,
  input  muldiv_pkg::rob_tag_t      mul_tag_i,
  input  logic                      mul_ready_i,
  output logic                      mul_stall_o,

  // divide reservation station
  input  logic [`MULDIV_DATA_W-1:0] div_val1_i,
  input  logic [`MULDIV_DATA_W-1:0] div_val2_i,
  input  logic [`MULDIV_CMD_W-1:0]  div_cmd_i,
  input  muldiv_pkg::rob_tag_t      div_tag_i,
  input  logic                      div_ready_i,
  output logic                      div_stall_o,

  // result bus toward the reorder buffer
  output logic [`MULDIV_DATA_W-1:0] result_val_o,
  output logic [`MULDIV_CMD_W-1:0]  result_cmd_o,
  output muldiv_pkg::rob_tag_t      result_tag_o,
  output muldiv_pkg::exec_flags_t   result_flags_o,
  output logic                      result_valid_o,
  input  logic                      result_ready_i
);
  import muldiv_pkg::*;

  cmd_u mul_cmd;
  cmd_u div_cmd;

  exec_result_if mul_res_if ();
  exec_result_if div_res_if ();

  // raw command words viewed through the shared union
  assign mul_cmd = mul_cmd_i;
  assign div_cmd = div_cmd_i;

  mult_issue_stage u_mul_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .val1_i  (mul_val1_i),
    .val2_i  (mul_val2_i),
    .cmd_i   (mul_cmd),
    .tag_i   (mul_tag_i),
    .ready_i (mul_ready_i),
    .stall_o (mul_stall_o),
    .res     (mul_res_if.unit)
  );

  div_issue_stage u_div_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .val1_i  (div_val1_i),
    .val2_i  (div_val2_i),
    .cmd_i   (div_cmd),
    .tag_i   (div_tag_i),
    .ready_i (div_ready_i),
    .stall_o (div_stall_o),
    .res     (div_res_if.unit)
  );

  result_arbiter u_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .mul_res        (mul_res_if.arbiter),
    .div_res        (div_res_if.arbiter),
    .result_val_o   (result_val_o),
    .result_cmd_o   (result_cmd_o),
    .result_tag_o   (result_tag_o),
    .result_flags_o (result_flags_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

// ==== muldiv_sva.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_sva (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      mul_stall_i,
  input logic                      div_stall_i,
  input logic                      mul_hold_i,
  input logic                      div_hold_i,
  input logic [`MULDIV_DATA_W-1:0] result_val_i,
  input logic [`MULDIV_CMD_W-1:0]  result_cmd_i,
  input muldiv_pkg::rob_tag_t      result_tag_i,
  input muldiv_pkg::exec_flags_t   result_flags_i,
  input logic                      result_valid_i,
  input logic                      result_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // a stalled result stays on the bus unchanged
  hold_while_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (result_valid_i && !result_ready_i) |=>
        (result_valid_i && $stable(result_val_i) && $stable(result_cmd_i) &&
         $stable(result_tag_i) && $stable(result_flags_i)))
    else $error("result bus changed before the result was taken");

  idle_after_reset: assert property (@(posedge clk_i)
      !rst_n_i |=> !result_valid_i)
    else $error("result bus valid right after reset");

  // a unit holding a finished result must not take new work
  mul_busy_while_holding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mul_hold_i |-> mul_stall_i)
    else $error("multiply stage open for issue while holding a result");

  div_busy_while_holding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      div_hold_i |-> div_stall_i)
    else $error("divide stage open for issue while holding a result");

endmodule

bind muldiv_exec_unit muldiv_sva u_sva (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .mul_stall_i    (mul_stall_o),
  .div_stall_i    (div_stall_o),
  .mul_hold_i     (mul_res_if.valid),
  .div_hold_i     (div_res_if.valid),
  .result_val_i   (result_val_o),
  .result_cmd_i   (result_cmd_o),
  .result_tag_i   (result_tag_o),
  .result_flags_i (result_flags_o),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i)
);

`default_nettype wire

// ==== muldiv_tb.sv ====
`default_nettype none

`include "muldiv_settings.svh"

module muldiv_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import muldiv_pkg::*;

  localparam int W = `MULDIV_DATA_W;
  localparam int CMD_W = `MULDIV_CMD_W;
  localparam int NTAGS = 2 ** TAG_W;
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_OPS = 48;
  localparam int CYCLES_PER_OP = 200;
  localparam int READY_ALWAYS = 0;
  localparam int READY_HELD = 1;
  localparam int READY_RANDOM = 2;
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  logic             clk;
  logic             rst_n;
  logic [W-1:0]     mul_val1;
  logic [W-1:0]     mul_val2;
  logic [CMD_W-1:0] mul_cmd;
  rob_tag_t         mul_tag;
  logic             mul_ready;
  logic             mul_stall;
  logic [W-1:0]     div_val1;
  logic [W-1:0]     div_val2;
  logic [CMD_W-1:0] div_cmd;
  rob_tag_t         div_tag;
  logic             div_ready;
  logic             div_stall;
  logic [W-1:0]     result_val;
  logic [CMD_W-1:0] result_cmd;
  rob_tag_t         result_tag;
  exec_flags_t      result_flags;
  logic             result_valid;
  logic             result_ready;

  // model table, one entry per tag
  logic [W-1:0]     exp_val   [NTAGS];
  exec_flags_t      exp_flags [NTAGS];
  logic [CMD_W-1:0] exp_cmd   [NTAGS];
  unit_id_e         unit_of   [NTAGS];
  int               issued_cnt   [NTAGS] = '{default: 0};
  int               returned_cnt [NTAGS] = '{default: 0};
  rob_tag_t         next_tag = '0;
  int               issued = 0;
  int               returned = 0;
  int               errors = 0;
  int               ready_mode = READY_ALWAYS;
  logic             xfer;
  logic             both_held;
  unit_id_e         bus_unit;

  muldiv_exec_unit dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .mul_val1_i     (mul_val1),
    .mul_val2_i     (mul_val2),
    .mul_cmd_i      (mul_cmd),
    .mul_tag_i      (mul_tag),
    .mul_ready_i    (mul_ready),
    .mul_stall_o    (mul_stall),
    .div_val1_i     (div_val1),
    .div_val2_i     (div_val2),
    .div_cmd_i      (div_cmd),
    .div_tag_i      (div_tag),
    .div_ready_i    (div_ready),
    .div_stall_o    (div_stall),
    .result_val_o   (result_val),
    .result_cmd_o   (result_cmd),
    .result_tag_o   (result_tag),
    .result_flags_o (result_flags),
    .result_valid_o (result_valid),
    .result_ready_i (result_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign xfer      = result_valid & result_ready;
  assign both_held = dut_i.mul_res_if.valid & dut_i.div_res_if.valid;
  assign bus_unit  = unit_of[result_tag];

  // reorder buffer side, stalls according to the current mode
  always @(negedge clk) begin
    case (ready_mode)
      READY_ALWAYS: result_ready = 1'b1;
      READY_HELD:   result_ready = 1'b0;
      default:      result_ready = ($urandom % 4) != 0;
    endcase
  end

  always @(posedge clk) begin
    if (rst_n && xfer) begin
      returned_cnt[result_tag] <= returned_cnt[result_tag] + 1;
      returned                 <= returned + 1;
    end
  end

  check_value: assert property (@(posedge clk) disable iff (!rst_n)
      xfer |-> result_val == exp_val[result_tag])
    else begin
      $display("FAILED result_val_o tag %h expected %h got %h", $sampled(result_tag),
               exp_val[$sampled(result_tag)], $sampled(result_val));
      errors++;
    end

  check_flags: assert property (@(posedge clk) disable iff (!rst_n)
      xfer |-> result_flags == exp_flags[result_tag])
    else begin
      $display("FAILED result_flags_o tag %h expected %h got %h", $sampled(result_tag),
               exp_flags[$sampled(result_tag)], $sampled(result_flags));
      errors++;
    end

  check_cmd: assert property (@(posedge clk) disable iff (!rst_n)
      xfer |-> result_cmd == exp_cmd[result_tag])
    else begin
      $display("FAILED result_cmd_o tag %h expected %h got %h", $sampled(result_tag),
               exp_cmd[$sampled(result_tag)], $sampled(result_cmd));
      errors++;
    end

  // every issued tag comes back exactly once
  check_tag_once: assert property (@(posedge clk) disable iff (!rst_n)
      xfer |-> issued_cnt[result_tag] == returned_cnt[result_tag] + 1)
    else begin
      $display("tag %h came back without a matching outstanding operation",
               $sampled(result_tag));
      errors++;
    end

  check_alternation: assert property (@(posedge clk) disable iff (!rst_n)
      (xfer && both_held) |=> (result_valid && bus_unit != $past(bus_unit)))
    else begin
      $display("results held by both units did not leave in alternating order");
      errors++;
    end

  check_mul_accept: assert property (@(posedge clk) disable iff (!rst_n)
      (mul_ready && !mul_stall) |=> mul_stall)
    else begin
      $display("multiply stage did not take an operation offered while idle");
      errors++;
    end

  check_div_accept: assert property (@(posedge clk) disable iff (!rst_n)
      (div_ready && !div_stall) |=> div_stall)
    else begin
      $display("divide stage did not take an operation offered while idle");
      errors++;
    end

  check_reset_state: assert property (@(posedge clk)
      $rose(rst_n) |-> (!mul_stall && !div_stall && !result_valid))
    else begin
      $display("after reset a stage is stalled or the result bus is valid");
      errors++;
    end

  function automatic logic [W-1:0] random_word();
    return {$urandom, $urandom};
  endfunction

  // expected {flags, value} of a multiply, from a full width product
  function automatic logic [W+3:0] expect_mul(logic [W-1:0] a, logic [W-1:0] b, cmd_u cmd);
    logic [2*W-1:0] a_ext;
    logic [2*W-1:0] b_ext;
    logic [2*W-1:0] prod;
    logic [W-1:0]   used;
    logic [W-1:0]   other;
    logic           ext_bit;
    exec_flags_t    f;
    a_ext   = cmd.mul.a_signed ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
    b_ext   = cmd.mul.b_signed ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
    prod    = a_ext * b_ext;
    used    = cmd.mul.high_half ? prod[2*W-1:W] : prod[W-1:0];
    other   = cmd.mul.high_half ? prod[W-1:0] : prod[2*W-1:W];
    ext_bit = (cmd.mul.a_signed | cmd.mul.b_signed) & used[W-1];
    f.zero        = (used == '0);
    f.negative    = used[W-1];
    f.overflow    = (other != {W{ext_bit}});
    f.div_by_zero = 1'b0;
    return {f, used};
  endfunction

  function automatic logic [W+3:0] expect_div(logic [W-1:0] a, logic [W-1:0] b, cmd_u cmd);
    logic [W-1:0] q;
    logic [W-1:0] r;
    logic [W-1:0] used;
    exec_flags_t  f;
    f = '0;
    if (b == '0) begin
      q = '1;
      r = a;
      f.div_by_zero = 1'b1;
    end else if (cmd.div.is_signed && a == MOST_NEG && b == '1) begin
      q = MOST_NEG;
      r = '0;
      f.overflow = 1'b1;
    end else if (cmd.div.is_signed) begin
      // truncating division, remainder follows the dividend
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    used = cmd.div.want_remainder ? r : q;
    f.zero     = (used == '0);
    f.negative = used[W-1];
    return {f, used};
  endfunction

  task automatic record_op(input rob_tag_t tag, input logic [W+3:0] model,
                           input logic [CMD_W-1:0] cmd, input unit_id_e unit);
    exp_flags[tag] = model[W+3:W];
    exp_val[tag]   = model[W-1:0];
    exp_cmd[tag]   = cmd;
    unit_of[tag]   = unit;
    issued_cnt[tag] = issued_cnt[tag] + 1;
    issued = issued + 1;
  endtask

  task automatic issue_mul(input logic [W-1:0] a, input logic [W-1:0] b,
                           input logic a_s, input logic b_s, input logic hi);
    cmd_u cmd;
    cmd = '0;
    cmd.mul.op_class  = 4'h1;
    cmd.mul.a_signed  = a_s;
    cmd.mul.b_signed  = b_s;
    cmd.mul.high_half = hi;
    @(negedge clk);
    while (mul_stall) begin
      @(negedge clk);
    end
    mul_val1  = a;
    mul_val2  = b;
    mul_cmd   = cmd;
    mul_tag   = next_tag;
    mul_ready = 1'b1;
    record_op(next_tag, expect_mul(a, b, cmd), cmd, UNIT_MUL);
    next_tag++;
    @(negedge clk);
    mul_ready = 1'b0;
  endtask

  task automatic issue_div(input logic [W-1:0] a, input logic [W-1:0] b,
                           input logic sgn, input logic rem);
    cmd_u cmd;
    cmd = '0;
    cmd.div.op_class       = 4'h2;
    cmd.div.is_signed      = sgn;
    cmd.div.want_remainder = rem;
    @(negedge clk);
    while (div_stall) begin
      @(negedge clk);
    end
    div_val1  = a;
    div_val2  = b;
    div_cmd   = cmd;
    div_tag   = next_tag;
    div_ready = 1'b1;
    record_op(next_tag, expect_div(a, b, cmd), cmd, UNIT_DIV);
    next_tag++;
    @(negedge clk);
    div_ready = 1'b0;
  endtask

  task automatic run_mul_directed();
    for (int combo = 0; combo < 8; combo++) begin
      issue_mul(random_word(), random_word(), combo[2], combo[1], combo[0]);
    end
    issue_mul('1, '1, 1'b1, 1'b1, 1'b0);
    issue_mul(MOST_NEG, MOST_NEG, 1'b1, 1'b1, 1'b1);
    issue_mul(64'h1_0000_0000, 64'h1_0000_0000, 1'b0, 1'b0, 1'b0);
    issue_mul('0, random_word(), 1'b1, 1'b0, 1'b1);
  endtask

  task automatic run_div_directed();
    for (int combo = 0; combo < 4; combo++) begin
      issue_div(random_word(), random_word() >> ($urandom % 60), combo[1], combo[0]);
    end
    issue_div(-64'd7, 64'd2, 1'b1, 1'b0);
    issue_div(-64'd7, 64'd2, 1'b1, 1'b1);
    issue_div(random_word(), '0, 1'b1, 1'b0);
    issue_div(random_word(), '0, 1'b0, 1'b1);
    issue_div(MOST_NEG, '1, 1'b1, 1'b0);
    issue_div(MOST_NEG, '1, 1'b1, 1'b1);
  endtask

  task automatic run_random_muls(input int n);
    for (int i = 0; i < n; i++) begin
      issue_mul(random_word(), random_word(), 1'($urandom % 2), 1'($urandom % 2),
                1'($urandom % 2));
    end
  endtask

  task automatic run_random_divs(input int n);
    for (int i = 0; i < n; i++) begin
      issue_div(random_word(), random_word() >> ($urandom % 64), 1'($urandom % 2),
                1'($urandom % 2));
    end
  endtask

  task automatic wait_drained();
    while (returned != issued) begin
      @(negedge clk);
    end
  endtask

  // mode changes on the rising edge so the next falling edge sees them
  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
  endtask

  initial begin
    repeat (RESET_CYCLES + CYCLES_PER_OP * NUM_OPS) @(posedge clk);
    $display("timeout: the operations did not all complete in the allowed time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    void'($urandom(68748));
    clk       = 1'b0;
    rst_n     = 1'b0;
    mul_val1  = '0;
    mul_val2  = '0;
    mul_cmd   = '0;
    mul_tag   = '0;
    mul_ready = 1'b0;
    div_val1  = '0;
    div_val2  = '0;
    div_cmd   = '0;
    div_tag   = '0;
    div_ready = 1'b0;
    result_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fork
      run_mul_directed();
      run_div_directed();
    join
    wait_drained();

    // both units finish while the bus is stalled
    set_ready_mode(READY_HELD);
    fork
      issue_mul(random_word(), random_word(), 1'b1, 1'b0, 1'b1);
      issue_div(random_word(), 64'd12345, 1'b0, 1'b0);
    join
    repeat (70) @(negedge clk);
    set_ready_mode(READY_ALWAYS);
    wait_drained();

    set_ready_mode(READY_RANDOM);
    fork
      run_random_muls(12);
      run_random_divs(12);
    join
    wait_drained();

    $display("errors: %0d, issued: %0d, returned: %0d", errors, issued, returned);
    if (errors == 0 && issued == returned) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== muldiv_exec.f ====
+incdir+.
muldiv_pkg.sv
exec_result_if.sv
shift_add_multiplier.sv
mult_issue_stage.sv
div_issue_stage.sv
result_arbiter.sv
muldiv_exec_unit.sv
muldiv_sva.sv
muldiv_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module muldiv_tb -f muldiv_exec.f
	./obj_dir/Vmuldiv_tb | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
